/* src/chiplet_pkg.sv */
package chiplet_pkg;

    typedef logic [31:0] word_t; // bus and link data word

    // host address map
    localparam logic [31:0] TX_SEND_ADDR        = 32'h1004;
    localparam logic [31:0] STATUS_ADDR         = 32'h1008;
    localparam logic [31:0] TX_CACHE_START_ADDR = 32'h2000;

    // descriptor layout, start address sits in the low bits
    localparam int LEN_LSB = 16;
    localparam int LEN_W   = 5;

    // who drives the tx cache port
    typedef enum logic {
        BUS,
        FSM
    } owner_e;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DONE
    } sender_state_e;

endpackage

/* src/word_cache.sv */
`timescale 1ns/1ps

module word_cache #(
    parameter int CACHE_NUM_WORDS = 128,
    localparam int ADDR_WIDTH     = $clog2(4 * CACHE_NUM_WORDS)
) (
    input  logic                  clk,
    input  logic                  wen,
    input  logic                  ren,
    input  logic [ADDR_WIDTH-1:0] addr,
    input  chiplet_pkg::word_t    wdata,
    input  logic [3:0]            strobe,
    output chiplet_pkg::word_t    rdata
);

    chiplet_pkg::word_t mem [CACHE_NUM_WORDS];

    logic [ADDR_WIDTH-3:0] word_idx;

    assign word_idx = addr[ADDR_WIDTH-1:2]; // byte address in, word index out

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int b = 0; b < 4; b++) begin
                if (strobe[b]) mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
            end
        end
    end

    assign rdata = ren ? mem[word_idx] : '0;

    // decoder window and sender address are whole words inside the array
    a_addr_range: assert property (@(posedge clk)
        (wen || ren) |-> (addr[1:0] == 2'b00 && word_idx < CACHE_NUM_WORDS));

endmodule

/* src/msg_slot.sv */
`timescale 1ns/1ps

module msg_slot #(
    parameter int CACHE_NUM_WORDS = 128,
    localparam int ADDR_WIDTH     = $clog2(4 * CACHE_NUM_WORDS)
) (
    input  logic                          clk,
    input  logic                          n_rst,
    input  logic                          desc_we,
    input  chiplet_pkg::word_t            desc_wdata,
    input  logic                          send_trig,
    input  logic                          slot_clear,
    output logic                          pending,
    output logic [ADDR_WIDTH-1:0]         start,
    output logic [chiplet_pkg::LEN_W-1:0] len
);

    // descriptor fields
    always_ff @(posedge clk) begin
        if (desc_we) begin
            start <= desc_wdata[ADDR_WIDTH-1:0];
            len   <= desc_wdata[chiplet_pkg::LEN_LSB +: chiplet_pkg::LEN_W];
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            pending <= 1'b0;
        end else if (send_trig) begin
            pending <= 1'b1; // retrigger in the clear cycle keeps it queued
        end else if (slot_clear) begin
            pending <= 1'b0;
        end
    end

    // the sender only finishes slots that were queued
    a_clear_pending: assert property (@(posedge clk) disable iff (!n_rst)
        slot_clear |-> pending);

endmodule

/* src/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder #(
    parameter int NUM_MSGS        = 4,
    parameter int CACHE_NUM_WORDS = 128,
    localparam int ADDR_WIDTH     = $clog2(4 * CACHE_NUM_WORDS),
    localparam int MSG_ID_W       = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1
) (
    input  logic                                        clk,
    input  logic                                        n_rst,
    input  logic                                        bus_wen,
    input  logic                                        bus_ren,
    input  logic [31:0]                                 bus_addr,
    input  chiplet_pkg::word_t                          bus_wdata,
    input  logic [3:0]                                  bus_strobe,
    output chiplet_pkg::word_t                          bus_rdata,
    output logic                                        bus_error,
    output logic                                        bus_stall,
    output logic [NUM_MSGS-1:0]                         desc_we,
    output chiplet_pkg::word_t                          desc_wdata,
    output logic [NUM_MSGS-1:0]                         send_trig,
    input  logic [NUM_MSGS-1:0]                         slot_pending,
    input  logic [NUM_MSGS-1:0][ADDR_WIDTH-1:0]         slot_start,
    input  logic [NUM_MSGS-1:0][chiplet_pkg::LEN_W-1:0] slot_len,
    input  logic                                        fsm_ren,
    input  logic [ADDR_WIDTH-1:0]                       fsm_addr,
    output chiplet_pkg::word_t                          fsm_rdata,
    output logic                                        fsm_stall,
    output logic                                        cache_wen,
    output logic                                        cache_ren,
    output logic [ADDR_WIDTH-1:0]                       cache_addr,
    output chiplet_pkg::word_t                          cache_wdata,
    output logic [3:0]                                  cache_strobe,
    input  chiplet_pkg::word_t                          cache_rdata
);

    localparam logic [31:0] TABLE_BYTES = 32'(4 * NUM_MSGS);
    localparam logic [31:0] CACHE_END   = chiplet_pkg::TX_CACHE_START_ADDR
                                          + 32'(4 * CACHE_NUM_WORDS);

    chiplet_pkg::owner_e owner;
    logic [MSG_ID_W-1:0] tbl_idx;
    logic [MSG_ID_W-1:0] send_idx;
    logic                send_ok;
    logic                in_cache;
    logic                bus_access;
    chiplet_pkg::word_t  table_rdata;

    assign bus_access = bus_wen | bus_ren;
    assign tbl_idx    = bus_addr[2 +: MSG_ID_W];
    assign send_idx   = bus_wdata[MSG_ID_W-1:0];
    assign send_ok    = (bus_wdata < NUM_MSGS) && (slot_len[send_idx] != '0);
    assign in_cache   = (bus_addr >= chiplet_pkg::TX_CACHE_START_ADDR) && (bus_addr < CACHE_END);
    assign desc_wdata = {bus_wdata[31:2], 2'b00}; // start stays word aligned

    always_comb begin
        table_rdata = '0;
        table_rdata[ADDR_WIDTH-1:0] = slot_start[tbl_idx];
        table_rdata[chiplet_pkg::LEN_LSB +: chiplet_pkg::LEN_W] = slot_len[tbl_idx];
    end

    // sender gets the port one cycle after it asks
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            owner <= chiplet_pkg::BUS;
        end else begin
            owner <= fsm_ren ? chiplet_pkg::FSM : chiplet_pkg::BUS;
        end
    end

    always_comb begin
        bus_rdata    = '0;
        bus_error    = 1'b0;
        bus_stall    = 1'b0;
        desc_we      = '0;
        send_trig    = '0;
        cache_wen    = 1'b0;
        cache_ren    = 1'b0;
        cache_addr   = '0;
        cache_wdata  = bus_wdata;
        cache_strobe = '0;
        fsm_rdata    = cache_rdata;
        fsm_stall    = 1'b1;

        if (bus_addr < TABLE_BYTES) begin
            if (bus_ren) begin
                bus_rdata = table_rdata;
            end else if (bus_wen) begin
                desc_we[tbl_idx] = 1'b1;
            end
        end else if (bus_addr == chiplet_pkg::TX_SEND_ADDR) begin
            if (bus_wen) begin
                if (send_ok) send_trig[send_idx] = 1'b1;
                else bus_error = 1'b1; // bad id or empty slot
            end
        end else if (bus_addr == chiplet_pkg::STATUS_ADDR) begin
            bus_rdata[NUM_MSGS-1:0] = slot_pending;
        end else if (in_cache) begin
            if (owner == chiplet_pkg::BUS) begin
                cache_wen    = bus_wen;
                cache_ren    = bus_ren;
                cache_addr   = bus_addr[ADDR_WIDTH-1:0];
                cache_strobe = bus_strobe;
                bus_rdata    = cache_rdata;
            end else begin
                bus_stall = bus_access; // host waits out the transmission
            end
        end else begin
            bus_error = bus_access;
        end

        if (owner == chiplet_pkg::FSM) begin
            cache_ren  = fsm_ren;
            cache_addr = fsm_addr;
            fsm_stall  = 1'b0;
        end
    end

    // host never issues a read and a write at once, sender only reads
    a_cache_one_op: assert property (@(posedge clk) disable iff (!n_rst)
        !(cache_wen && cache_ren));

endmodule

/* src/tx_sender.sv */
`timescale 1ns/1ps

module tx_sender #(
    parameter int NUM_MSGS        = 4,
    parameter int CACHE_NUM_WORDS = 128,
    localparam int ADDR_WIDTH     = $clog2(4 * CACHE_NUM_WORDS),
    localparam int MSG_ID_W       = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1
) (
    input  logic                                        clk,
    input  logic                                        n_rst,
    input  logic [NUM_MSGS-1:0]                         slot_pending,
    input  logic [NUM_MSGS-1:0][ADDR_WIDTH-1:0]         slot_start,
    input  logic [NUM_MSGS-1:0][chiplet_pkg::LEN_W-1:0] slot_len,
    output logic [NUM_MSGS-1:0]                         slot_clear,
    output logic                                        fsm_ren,
    output logic [ADDR_WIDTH-1:0]                       fsm_addr,
    input  chiplet_pkg::word_t                          fsm_rdata,
    input  logic                                        fsm_stall,
    output logic                                        tx_valid,
    output chiplet_pkg::word_t                          tx_data,
    output logic                                        tx_last,
    output logic [MSG_ID_W-1:0]                         tx_msg_id
);

    chiplet_pkg::sender_state_e   state;
    logic [MSG_ID_W-1:0]          cur_slot;
    logic [MSG_ID_W-1:0]          pick;
    logic [ADDR_WIDTH-1:0]        rd_addr;
    logic [chiplet_pkg::LEN_W-1:0] count; // words still to send

    // lowest numbered pending slot wins
    always_comb begin
        pick = '0;
        for (int i = NUM_MSGS - 1; i >= 0; i--) begin
            if (slot_pending[i]) pick = MSG_ID_W'(i);
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state    <= chiplet_pkg::IDLE;
            cur_slot <= '0;
            rd_addr  <= '0;
            count    <= '0;
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
        end else begin
            tx_valid <= 1'b0;
            tx_last  <= 1'b0;
            case (state)
                chiplet_pkg::IDLE: begin
                    if (|slot_pending) begin
                        cur_slot <= pick;
                        rd_addr  <= slot_start[pick];
                        count    <= slot_len[pick];
                        // a slot rewritten to zero length is just retired
                        state    <= (slot_len[pick] == '0) ? chiplet_pkg::DONE
                                                           : chiplet_pkg::FETCH;
                    end
                end
                chiplet_pkg::FETCH: begin
                    if (!fsm_stall) begin
                        tx_valid <= 1'b1;
                        tx_last  <= (count == 1);
                        rd_addr  <= rd_addr + ADDR_WIDTH'(4);
                        count    <= count - 1'b1;
                        if (count == 1) state <= chiplet_pkg::DONE;
                    end
                end
                chiplet_pkg::DONE: begin
                    state <= chiplet_pkg::IDLE;
                end
                default: state <= chiplet_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == chiplet_pkg::FETCH && !fsm_stall) tx_data <= fsm_rdata;
    end

    assign fsm_ren   = (state == chiplet_pkg::FETCH);
    assign fsm_addr  = rd_addr;
    assign tx_msg_id = cur_slot; // held until the next pick, past the last word

    always_comb begin
        slot_clear = '0;
        if (state == chiplet_pkg::DONE) slot_clear[cur_slot] = 1'b1;
    end

    // the last word closes a packet whose slot is still queued
    a_last_framing: assert property (@(posedge clk) disable iff (!n_rst)
        tx_last |-> tx_valid && slot_pending[tx_msg_id]);

endmodule

/* src/endpoint_top.sv */
`timescale 1ns/1ps

module endpoint_top #(
    parameter int NUM_MSGS        = 4,
    parameter int CACHE_NUM_WORDS = 128,
    localparam int ADDR_WIDTH     = $clog2(4 * CACHE_NUM_WORDS),
    localparam int MSG_ID_W       = (NUM_MSGS > 1) ? $clog2(NUM_MSGS) : 1
) (
    input  logic                  clk,
    input  logic                  n_rst,
    input  logic                  bus_wen,
    input  logic                  bus_ren,
    input  logic [31:0]           bus_addr,
    input  chiplet_pkg::word_t    bus_wdata,
    input  logic [3:0]            bus_strobe,
    output chiplet_pkg::word_t    bus_rdata,
    output logic                  bus_error,
    output logic                  bus_stall,
    output logic                  tx_valid,
    output chiplet_pkg::word_t    tx_data,
    output logic                  tx_last,
    output logic [MSG_ID_W-1:0]   tx_msg_id
);

    logic [NUM_MSGS-1:0]                         desc_we;
    chiplet_pkg::word_t                          desc_wdata;
    logic [NUM_MSGS-1:0]                         send_trig;
    logic [NUM_MSGS-1:0]                         slot_clear;
    logic [NUM_MSGS-1:0]                         slot_pending;
    logic [NUM_MSGS-1:0][ADDR_WIDTH-1:0]         slot_start;
    logic [NUM_MSGS-1:0][chiplet_pkg::LEN_W-1:0] slot_len;

    logic                  fsm_ren;
    logic [ADDR_WIDTH-1:0] fsm_addr;
    chiplet_pkg::word_t    fsm_rdata;
    logic                  fsm_stall;

    logic                  cache_wen;
    logic                  cache_ren;
    logic [ADDR_WIDTH-1:0] cache_addr;
    chiplet_pkg::word_t    cache_wdata;
    logic [3:0]            cache_strobe;
    chiplet_pkg::word_t    cache_rdata;

    bus_decoder #(
        .NUM_MSGS       (NUM_MSGS),
        .CACHE_NUM_WORDS(CACHE_NUM_WORDS)
    ) u_decoder (
        .clk(clk), .n_rst(n_rst),
        .bus_wen(bus_wen), .bus_ren(bus_ren), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_strobe(bus_strobe),
        .bus_rdata(bus_rdata), .bus_error(bus_error), .bus_stall(bus_stall),
        .desc_we(desc_we), .desc_wdata(desc_wdata), .send_trig(send_trig),
        .slot_pending(slot_pending), .slot_start(slot_start), .slot_len(slot_len),
        .fsm_ren(fsm_ren), .fsm_addr(fsm_addr), .fsm_rdata(fsm_rdata), .fsm_stall(fsm_stall),
        .cache_wen(cache_wen), .cache_ren(cache_ren), .cache_addr(cache_addr),
        .cache_wdata(cache_wdata), .cache_strobe(cache_strobe), .cache_rdata(cache_rdata)
    );

    for (genvar i = 0; i < NUM_MSGS; i++) begin : g_slot
        msg_slot #(.CACHE_NUM_WORDS(CACHE_NUM_WORDS)) u_slot (
            .clk(clk), .n_rst(n_rst),
            .desc_we(desc_we[i]), .desc_wdata(desc_wdata),
            .send_trig(send_trig[i]), .slot_clear(slot_clear[i]),
            .pending(slot_pending[i]), .start(slot_start[i]), .len(slot_len[i])
        );
    end

    word_cache #(.CACHE_NUM_WORDS(CACHE_NUM_WORDS)) u_cache (
        .clk(clk), .wen(cache_wen), .ren(cache_ren), .addr(cache_addr),
        .wdata(cache_wdata), .strobe(cache_strobe), .rdata(cache_rdata)
    );

    tx_sender #(
        .NUM_MSGS       (NUM_MSGS),
        .CACHE_NUM_WORDS(CACHE_NUM_WORDS)
    ) u_sender (
        .clk(clk), .n_rst(n_rst),
        .slot_pending(slot_pending), .slot_start(slot_start), .slot_len(slot_len),
        .slot_clear(slot_clear),
        .fsm_ren(fsm_ren), .fsm_addr(fsm_addr), .fsm_rdata(fsm_rdata), .fsm_stall(fsm_stall),
        .tx_valid(tx_valid), .tx_data(tx_data), .tx_last(tx_last), .tx_msg_id(tx_msg_id)
    );

endmodule

/* verif/tb_endpoint.sv */
`timescale 1ns/1ps

module tb_endpoint;

    localparam int NUM_ENTRIES = 4;

    typedef struct packed {
        logic [7:0] msg;
        logic [7:0] start_word;
        logic [7:0] len;
        logic [7:0] seed_off;
    } pkt_t;

    // message, first cache word, length in words, seed offset
    pkt_t pkt_table [NUM_ENTRIES] = '{
        '{8'd0, 8'd0,  8'd5,  8'd1},
        '{8'd1, 8'd8,  8'd3,  8'd2},
        '{8'd2, 8'd16, 8'd12, 8'd3},
        '{8'd3, 8'd40, 8'd20, 8'd4}
    };

    logic               clk;
    logic               n_rst;
    logic               bus_wen;
    logic               bus_ren;
    logic [31:0]        bus_addr;
    chiplet_pkg::word_t bus_wdata;
    logic [3:0]         bus_strobe;
    chiplet_pkg::word_t bus_rdata;
    logic               bus_error;
    logic               bus_stall;
    logic               tx_valid;
    chiplet_pkg::word_t tx_data;
    logic               tx_last;
    logic [1:0]         tx_msg_id;

    chiplet_pkg::word_t model [128]; // expected cache contents
    logic [34:0]        exp_q [$];   // {last, msg id, data}
    integer             seed;
    integer             stall_cycles;

    endpoint_top dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    function automatic logic [31:0] cache_byte(input int idx);
        return chiplet_pkg::TX_CACHE_START_ADDR + 32'(4 * idx);
    endfunction

    task automatic wait_stall();
        #1;
        while (bus_stall) begin
            stall_cycles = stall_cycles + 1;
            @(negedge clk);
            #1;
        end
    endtask

    task automatic bus_write(input logic [31:0] addr, input chiplet_pkg::word_t data,
                             input logic [3:0] strobe, input logic exp_err);
        @(negedge clk);
        bus_wen    = 1'b1;
        bus_addr   = addr;
        bus_wdata  = data;
        bus_strobe = strobe;
        wait_stall();
        assert (bus_error == exp_err)
            else stop_on_error($sformatf("FAILED at %0t: write to %h gave error %b",
                                         $time, addr, bus_error));
        @(negedge clk);
        bus_wen = 1'b0;
    endtask

    task automatic bus_read(input logic [31:0] addr, input chiplet_pkg::word_t exp_data,
                            input logic exp_err);
        @(negedge clk);
        bus_ren  = 1'b1;
        bus_addr = addr;
        wait_stall();
        assert (bus_error == exp_err && (exp_err || bus_rdata == exp_data))
            else stop_on_error($sformatf("FAILED at %0t: read %h gave %h err %b, expected %h",
                                         $time, addr, bus_rdata, bus_error, exp_data));
        @(negedge clk);
        bus_ren = 1'b0;
    endtask

    task automatic send(input logic [7:0] msg, input logic exp_err);
        bus_write(chiplet_pkg::TX_SEND_ADDR, 32'(msg), 4'hf, exp_err);
    endtask

    // fill the packet's cache words and its descriptor
    task automatic load_packet(input pkt_t p);
        logic [31:0] desc;
        seed = 32'hc1fb + p.seed_off;
        for (int w = 0; w < int'(p.len); w++) begin
            model[p.start_word + w] = $random(seed);
            bus_write(cache_byte(p.start_word + w), model[p.start_word + w], 4'hf, 1'b0);
        end
        desc = (32'(p.len) << chiplet_pkg::LEN_LSB) | (32'(p.start_word) * 4);
        bus_write(32'(p.msg) * 4, desc | 32'h3, 4'hf, 1'b0); // low bits must read back clear
        bus_read(32'(p.msg) * 4, desc, 1'b0);
    endtask

    task automatic expect_packet(input pkt_t p);
        for (int w = 0; w < int'(p.len); w++) begin
            exp_q.push_back({w == int'(p.len) - 1, p.msg[1:0], model[p.start_word + w]});
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0) @(negedge clk);
    endtask

    // link monitor
    always @(negedge clk) begin
        if (n_rst && tx_valid) begin
            assert (exp_q.size() != 0)
                else stop_on_error($sformatf("link word %h at %0t arrived with no packet queued",
                                             tx_data, $time));
            assert ({tx_last, tx_msg_id, tx_data} == exp_q[0])
                else stop_on_error($sformatf(
                    "FAILED at %0t: link last %b id %0d data %h, expected %h",
                    $time, tx_last, tx_msg_id, tx_data, exp_q[0]));
            void'(exp_q.pop_front());
        end
    end

    initial begin
        n_rst        = 1'b0;
        bus_wen      = 1'b0;
        bus_ren      = 1'b0;
        bus_addr     = '0;
        bus_wdata    = '0;
        bus_strobe   = '0;
        stall_cycles = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;

        bus_write(cache_byte(100), 32'h1122_3344, 4'hf, 1'b0);
        bus_read(cache_byte(100), 32'h1122_3344, 1'b0);
        bus_write(cache_byte(100), 32'haabb_ccdd, 4'b0101, 1'b0);
        model[100] = 32'h11bb_33dd; // bytes 0 and 2 replaced
        bus_read(cache_byte(100), model[100], 1'b0);

        foreach (pkt_table[k]) begin
            load_packet(pkt_table[k]);
            expect_packet(pkt_table[k]);
            send(pkt_table[k].msg, 1'b0);
            wait_drain();
        end

        // slot 3 streams while 2, 1 and 0 queue behind it
        expect_packet(pkt_table[3]);
        send(pkt_table[3].msg, 1'b0);
        for (int k = 0; k < 3; k++) expect_packet(pkt_table[k]);
        for (int k = 2; k >= 0; k--) send(pkt_table[k].msg, 1'b0);
        bus_read(chiplet_pkg::STATUS_ADDR, 32'hf, 1'b0);
        wait_drain();
        bus_read(chiplet_pkg::STATUS_ADDR, 32'h0, 1'b0);

        send(8'd4, 1'b1);
        bus_write(32'd12, 32'(pkt_table[3].start_word) * 4, 4'hf, 1'b0); // slot 3 now empty
        send(pkt_table[3].msg, 1'b1);
        bus_read(32'h3000, 32'h0, 1'b1);
        bus_write(32'h1000, 32'h1, 4'hf, 1'b1);
        repeat (20) @(negedge clk);
        bus_read(chiplet_pkg::STATUS_ADDR, 32'h0, 1'b0);

        // host cache reads while slot 2 streams
        stall_cycles = 0;
        expect_packet(pkt_table[2]);
        send(pkt_table[2].msg, 1'b0);
        bus_read(cache_byte(100), model[100], 1'b0);
        for (int w = 16; w < 28; w += 4) bus_read(cache_byte(w), model[w], 1'b0);
        wait_drain();
        assert (stall_cycles > 0)
            else stop_on_error("host cache reads were never stalled during a transmission");

        $display("Simulation passed");
        $finish;
    end

    initial begin
        repeat (16 + 200 * NUM_ENTRIES + 1000) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles",
                 16 + 200 * NUM_ENTRIES + 1000);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

endmodule

/* chiplet_endpoint.f */
src/chiplet_pkg.sv
src/word_cache.sv
src/msg_slot.sv
src/bus_decoder.sv
src/tx_sender.sv
src/endpoint_top.sv
verif/tb_endpoint.sv

/* Makefile */
TOP := tb_endpoint

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

obj_dir/V$(TOP): chiplet_endpoint.f src/*.sv verif/*.sv
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f chiplet_endpoint.f

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f chiplet_endpoint.f

clean:
	rm -rf obj_dir
